/* build.f */
source/gamePkg.sv
source/lifeCtrlIf.sv
source/frameTick.sv
source/attackHitDetect.sv
source/enemyLife.sv
source/gameRegs.sv
source/gameLogicTop.sv
tests/clockGen.sv
tests/gameLogic_checker.sv
tests/gameLogicTb.sv

/* Makefile */
# Verilator build and run of the game logic testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module gameLogicTb -f build.f -o gameLogicSim

run: compile
	./obj_dir/gameLogicSim | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/gameLogicTb.sv */
`timescale 1ns/1ps
`default_nettype none

module gameLogicTb;

    localparam int MaxHealth = 100;
    localparam int TickDivide = 4;

    logic Clk, rstN, frameClk, attackOn;
    logic [1:0] playerDirection;
    logic [8:0] attackX, attackY, enemyX, enemyY;
    logic psel, penable, pwrite, pready, pslverr, enemyAlive;
    logic [3:0] paddr;
    logic [31:0] pwdata, prdata, rngState;
    logic [7:0] score;

    int errors, testsRun, errStart, frameEdges;
    int modelHealth, modelScore, modelDamage, modelRespawn;

    clockGen uClockGen (
        .Clk(Clk),
        .rstN(rstN)
    );

    gameLogicTop #(
        .MaxHealth(MaxHealth),
        .TickDivide(TickDivide)
    ) u_gameLogicTop (.*);

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic bit spansMeet(input int aLo, input int aHi, input int bLo, input int bHi);
        return (aLo <= bHi) && (bLo <= aHi);
    endfunction

    // Box overlap per facing direction in signed ints so left and up boxes may go negative
    function automatic bit boxHit(input int dir, input int ax, input int ay, input int ex,
                                  input int ey);
        int s;
        int l;
        int e;
        s = gamePkg::attackShort;
        l = gamePkg::attackLong;
        e = gamePkg::enemySize;
        case (dir)
            0: return spansMeet(ex, ex + e, ax, ax + s) && spansMeet(ey, ey + e, ay, ay + l);
            1: return spansMeet(ex, ex + e, ax - l, ax) && spansMeet(ey, ey + e, ay, ay + s);
            2: return spansMeet(ex, ex + e, ax, ax + s) && spansMeet(ey, ey + e, ay - l, ay);
            default: return spansMeet(ex, ex + e, ax, ax + l) && spansMeet(ey, ey + e, ay, ay + s);
        endcase
    endfunction

    task automatic step();
        @(posedge Clk);
        #2;
    endtask

    task automatic failValue(input string what, input int got, input int exp);
        $display("[FAIL] %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
        errors++;
    endtask

    task automatic failText(input string what);
        $display("Check failed at %0d ns: %s", $time, what);
        errors++;
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        $display("%s: %0d errors", name, errors - errStart);
        errStart = errors;
    endtask

    task automatic apbTransfer(input logic [3:0] addr, input logic write,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        int n;
        step();
        psel = 1'b1;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        step();
        penable = 1'b1;
        #3;
        for (n = 0; n < 16 && pready !== 1'b1; n++) begin
            step();
            #3;
        end
        if (pready !== 1'b1) failText("timed out waiting for pready");
        rdata = prdata;
        err = pslverr;
        step();
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic err;
        apbTransfer(addr, 1'b1, data, unused, err);
        if (err) failText("pslverr on a mapped write");
    endtask

    task automatic readCheck(input logic [3:0] addr, input int exp, input string what);
        logic [31:0] data;
        logic err;
        apbTransfer(addr, 1'b0, 32'd0, data, err);
        if (err) failText({what, ": pslverr on a mapped read"});
        if (int'(data) != exp) failValue(what, int'(data), exp);
    endtask

    // Status word is alive at 16, health at 14:8, score at 7:0
    task automatic checkStatus(input string what);
        int alive;
        alive = (modelHealth != 0) ? 1 : 0;
        readCheck(gamePkg::regStatus, (alive << 16) | (modelHealth << 8) | modelScore, what);
    endtask

    task automatic modelHit();
        if (modelHealth > 0) begin
            modelHealth = (modelHealth > modelDamage) ? modelHealth - modelDamage : 0;
            if (modelScore < 255) modelScore++;
        end
    endtask

    task automatic aimAtEnemy();
        playerDirection = 2'd0;
        attackX = 9'd100;
        attackY = 9'd100;
        enemyX = 9'd105;
        enemyY = 9'd150;
    endtask

    task automatic strike();
        step();
        attackOn = 1'b1;
        step();
        attackOn = 1'b0;
        repeat (3) step();
        modelHit();
    endtask

    // Frame strobe of 10 cycles high and 10 low that waits out the reset
    initial begin : frameGen
        int phase;
        frameClk = 1'b0;
        frameEdges = 0;
        phase = 0;
        forever begin
            @(posedge Clk);
            #1;
            if (rstN === 1'b1) begin
                phase++;
                if (phase == 10) begin
                    phase = 0;
                    if (!frameClk) frameEdges++;
                    #1;
                    frameClk = ~frameClk;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] data;
        logic err;
        int n;
        int late;
        int deadTicks;
        bit pipeA;
        bit pipeB;
        bit done;

        attackOn = 1'b0;
        playerDirection = 2'd0;
        attackX = 9'd0;
        attackY = 9'd0;
        enemyX = 9'd0;
        enemyY = 9'd0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 4'd0;
        pwdata = 32'd0;
        rngState = 32'h544802cb;
        errors = 0;
        testsRun = 0;
        errStart = 0;
        modelHealth = MaxHealth;
        modelScore = 0;
        modelDamage = 100;
        modelRespawn = 200;
        for (n = 0; n < 10 && rstN !== 1'b1; n++) step();
        if (rstN !== 1'b1) failText("timed out waiting for reset release");

        readCheck(gamePkg::regDamage, modelDamage, "damage after reset");
        readCheck(gamePkg::regRespawn, modelRespawn, "respawn after reset");
        checkStatus("status after reset");
        for (n = 0; n < 4; n++) begin
            r = nextRand();
            apbWrite(gamePkg::regDamage, r);
            modelDamage = int'(r[6:0]);
            readCheck(gamePkg::regDamage, modelDamage, "damage readback");
            r = nextRand();
            apbWrite(gamePkg::regRespawn, r);
            modelRespawn = int'(r[9:0]);
            readCheck(gamePkg::regRespawn, modelRespawn, "respawn readback");
        end
        apbTransfer(4'h2, 1'b0, 32'd0, data, err);
        if (err !== 1'b1) failValue("pslverr for unmapped address", int'(err), 1);
        finishTest("register access");

        // Score at the ports trails each stimulus by two cycles
        apbWrite(gamePkg::regDamage, 32'd0);
        modelDamage = 0;
        pipeA = 1'b0;
        pipeB = 1'b0;
        for (n = 0; n < 302; n++) begin
            step();
            if (pipeB) modelHit();
            if (int'(score) != modelScore) failValue("score after attack", int'(score), modelScore);
            pipeB = pipeA;
            r = nextRand();
            enemyX = r[8:0];
            enemyY = r[17:9];
            playerDirection = r[19:18];
            attackOn = r[20] && (n < 300);
            r = nextRand();
            attackX = enemyX + {1'b0, r[7:0]} - 9'd128;
            attackY = enemyY + {1'b0, r[15:8]} - 9'd128;
            pipeA = attackOn && boxHit(int'(playerDirection), int'(attackX), int'(attackY),
                                       int'(enemyX), int'(enemyY));
        end
        finishTest("directional hits");

        aimAtEnemy();
        apbWrite(gamePkg::regRespawn, 32'd5);
        modelRespawn = 5;
        apbWrite(gamePkg::regDamage, 32'd60);
        modelDamage = 60;
        // Kill right after a tick so none is in flight at death
        deadTicks = frameEdges / TickDivide;
        for (n = 0; n < 200 && frameEdges / TickDivide == deadTicks; n++) step();
        if (frameEdges / TickDivide == deadTicks) failText("timed out waiting for a game tick");
        repeat (4) step();
        strike();
        checkStatus("status after first hit");
        strike();
        checkStatus("status after second hit");
        deadTicks = frameEdges / TickDivide;
        if (enemyAlive !== 1'b0) failText("enemy still alive at zero health");
        strike();
        checkStatus("status after hit while dead");
        done = 1'b0;
        late = 0;
        for (n = 0; n < 1000 && !done; n++) begin
            step();
            if (frameEdges / TickDivide - deadTicks <= modelRespawn) begin
                if (enemyAlive !== 1'b0) begin
                    failText("enemy respawned before the respawn time");
                    done = 1'b1;
                end
            end else begin
                late++;
                if (enemyAlive === 1'b1) begin
                    done = 1'b1;
                end else if (late > 4) begin
                    failText("enemy did not respawn within 4 cycles of the tick");
                    done = 1'b1;
                end
            end
        end
        if (!done) failText("timed out waiting for respawn");
        modelHealth = MaxHealth;
        checkStatus("status after respawn");
        finishTest("kill and respawn");

        apbWrite(gamePkg::regDamage, 32'd0);
        modelDamage = 0;
        step();
        attackOn = 1'b1;
        repeat (300) step();
        attackOn = 1'b0;
        repeat (3) step();
        for (n = 0; n < 300; n++) modelHit();
        if (int'(score) != modelScore) failValue("saturated score", int'(score), modelScore);
        checkStatus("status after 300 hits");
        apbWrite(gamePkg::regCtrl, 32'd1);
        modelScore = 0;
        checkStatus("status after score clear");
        finishTest("score saturation");

        apbWrite(gamePkg::regDamage, 32'd127);
        modelDamage = 127;
        strike();
        checkStatus("status after overkill hit");
        if (enemyAlive !== 1'b0) failText("enemy alive after overkill hit");
        finishTest("health saturation");

        $display("%0d tests run, %0d errors", testsRun, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/gameLogic_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module gameLogic_checker #(
    parameter int MaxHealth = 100
) (
    input wire Clk,
    input wire rstN,
    input wire pready,
    input wire [gamePkg::healthW-1:0] health,
    input wire alive,
    input wire [7:0] score,
    input wire scoreClear
);

    readyHigh: assert property (@(posedge Clk) disable iff (!rstN) pready)
        else $error("pready dropped");

    healthBound: assert property (@(posedge Clk) disable iff (!rstN) int'(health) <= MaxHealth)
        else $error("health above its maximum");

    aliveMatch: assert property (@(posedge Clk) disable iff (!rstN) alive == (health != '0))
        else $error("alive does not follow health");

    // Only a clear may lower the score
    scoreRise: assert property (@(posedge Clk) disable iff (!rstN)
        !$past(scoreClear) |-> score >= $past(score))
        else $error("score decreased without a clear");

endmodule

bind gameLogicTop gameLogic_checker #(
    .MaxHealth(MaxHealth)
) uChecker (
    .Clk(Clk),
    .rstN(rstN),
    .pready(pready),
    .health(lifeLink.health),
    .alive(enemyAlive),
    .score(score),
    .scoreClear(lifeLink.scoreClear)
);

`default_nettype wire

/* tests/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HalfPeriod = 10,
    parameter int ResetCycles = 3
) (
    output logic Clk,
    output logic rstN
);

    initial begin
        Clk = 1'b0;
        forever #HalfPeriod Clk = ~Clk;
    end

    // Released shortly after the last reset edge
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        #2;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

/* source/gameLogicTop.sv */
`timescale 1ns/1ps
`default_nettype none

module gameLogicTop #(
    parameter int MaxHealth = 100,
    parameter int TickDivide = 4
) (
    input wire Clk,
    input wire rstN,
    input wire frameClk,
    input wire attackOn,
    input wire [1:0] playerDirection,
    input wire [gamePkg::coordW-1:0] attackX,
    input wire [gamePkg::coordW-1:0] attackY,
    input wire [gamePkg::coordW-1:0] enemyX,
    input wire [gamePkg::coordW-1:0] enemyY,
    input wire psel,
    input wire penable,
    input wire pwrite,
    input wire [3:0] paddr,
    input wire [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic enemyAlive,
    output logic [7:0] score
);

    logic tick;
    logic hit;

    lifeCtrlIf lifeLink ();

    frameTick #(
        .TickDivide(TickDivide)
    ) uFrameTick (
        .Clk(Clk),
        .rstN(rstN),
        .frameClk(frameClk),
        .tick(tick)
    );

    attackHitDetect uHitDetect (
        .Clk(Clk),
        .rstN(rstN),
        .attackOn(attackOn),
        .playerDirection(gamePkg::dirE'(playerDirection)),
        .attackX(attackX),
        .attackY(attackY),
        .enemyX(enemyX),
        .enemyY(enemyY),
        .hit(hit)
    );

    enemyLife #(
        .MaxHealth(MaxHealth)
    ) uEnemyLife (
        .Clk(Clk),
        .rstN(rstN),
        .hit(hit),
        .tick(tick),
        .ctrl(lifeLink.life)
    );

    gameRegs uGameRegs (
        .Clk(Clk),
        .rstN(rstN),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .ctrl(lifeLink.regs)
    );

    assign enemyAlive = lifeLink.alive;
    assign score = lifeLink.score;

endmodule

`default_nettype wire

/* source/gameRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module gameRegs (
    input wire Clk,
    input wire rstN,
    input wire psel,
    input wire penable,
    input wire pwrite,
    input wire [3:0] paddr,
    input wire [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    lifeCtrlIf.regs ctrl
);

    localparam int HealthW = gamePkg::healthW;
    localparam int RespawnW = gamePkg::respawnW;

    logic access;
    logic addrValid;
    gamePkg::regAddrE regSel;
    logic [31:0] rdData;
    logic [HealthW-1:0] damageReg;
    logic [RespawnW-1:0] respawnReg;

    assign access = psel & penable;
    assign regSel = gamePkg::regAddrE'(paddr);

    // Zero-wait slave
    assign pready = 1'b1;

    always_comb begin
        addrValid = 1'b1;
        rdData = '0;
        case (regSel)
            gamePkg::regCtrl: rdData = '0;
            gamePkg::regDamage: rdData = {{(32 - HealthW){1'b0}}, damageReg};
            gamePkg::regRespawn: rdData = {{(32 - RespawnW){1'b0}}, respawnReg};
            gamePkg::regStatus: begin
                rdData = {15'd0, ctrl.alive, 1'b0, ctrl.health, ctrl.score};
            end
            default: addrValid = 1'b0;
        endcase
    end

    assign prdata = access ? rdData : '0;
    assign pslverr = access & ~addrValid;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            damageReg <= gamePkg::damageReset;
            respawnReg <= gamePkg::respawnReset;
        end else if (access && pwrite) begin
            // Status writes fall through silently
            case (regSel)
                gamePkg::regDamage: damageReg <= pwdata[HealthW-1:0];
                gamePkg::regRespawn: respawnReg <= pwdata[RespawnW-1:0];
                default: ;
            endcase
        end
    end

    // Score clear pulses for the single access cycle
    assign ctrl.scoreClear = access & pwrite & (regSel == gamePkg::regCtrl) & pwdata[0];

    assign ctrl.damage = damageReg;
    assign ctrl.respawnTime = respawnReg;

endmodule

`default_nettype wire

/* source/enemyLife.sv */
`timescale 1ns/1ps
`default_nettype none

module enemyLife #(
    parameter int MaxHealth = 100
) (
    input wire Clk,
    input wire rstN,
    input wire hit,
    input wire tick,
    lifeCtrlIf.life ctrl
);

    localparam int HealthW = gamePkg::healthW;
    localparam int RespawnW = gamePkg::respawnW;
    localparam logic [HealthW-1:0] FullHealth = HealthW'(MaxHealth);

    logic [HealthW-1:0] health;
    logic [RespawnW-1:0] respawnCnt;
    logic [7:0] score;
    logic alive;

    assign alive = (health != '0);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            health <= FullHealth;
            respawnCnt <= '0;
        end else if (alive) begin
            if (hit) begin
                // Saturate at zero
                if (health > ctrl.damage) begin
                    health <= health - ctrl.damage;
                end else begin
                    health <= '0;
                end
            end
        end else if (tick) begin
            if (respawnCnt == ctrl.respawnTime) begin
                health <= FullHealth;
                respawnCnt <= '0;
            end else begin
                respawnCnt <= respawnCnt + 1'b1;
            end
        end
    end

    // Clear wins over a same-cycle hit
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            score <= '0;
        end else if (ctrl.scoreClear) begin
            score <= '0;
        end else if (alive && hit && (score != 8'hFF)) begin
            score <= score + 1'b1;
        end
    end

    assign ctrl.score = score;
    assign ctrl.health = health;
    assign ctrl.alive = alive;

endmodule

`default_nettype wire

/* source/attackHitDetect.sv */
`timescale 1ns/1ps
`default_nettype none

module attackHitDetect (
    input wire Clk,
    input wire rstN,
    input wire attackOn,
    input wire gamePkg::dirE playerDirection,
    input wire [gamePkg::coordW-1:0] attackX,
    input wire [gamePkg::coordW-1:0] attackY,
    input wire [gamePkg::coordW-1:0] enemyX,
    input wire [gamePkg::coordW-1:0] enemyY,
    output logic hit
);

    // One spare bit so that end points never wrap
    localparam int WideW = gamePkg::coordW + 1;
    localparam logic [WideW-1:0] Short = WideW'(gamePkg::attackShort);
    localparam logic [WideW-1:0] Long = WideW'(gamePkg::attackLong);
    localparam logic [WideW-1:0] Size = WideW'(gamePkg::enemySize);

    logic [WideW-1:0] ax;
    logic [WideW-1:0] ay;
    logic [WideW-1:0] ex;
    logic [WideW-1:0] ey;
    logic overlap;

    // Inclusive span test
    function automatic logic meets(
        input logic [WideW-1:0] aLo,
        input logic [WideW-1:0] aHi,
        input logic [WideW-1:0] bLo,
        input logic [WideW-1:0] bHi
    );
        return (aLo <= bHi) && (bLo <= aHi);
    endfunction

    assign ax = {1'b0, attackX};
    assign ay = {1'b0, attackY};
    assign ex = {1'b0, enemyX};
    assign ey = {1'b0, enemyY};

    // Left and up boxes reach below the attack point
    // Their long side is added to the enemy span instead
    always_comb begin
        case (playerDirection)
            gamePkg::dirDown: begin
                overlap = meets(ex, ex + Size, ax, ax + Short)
                       && meets(ey, ey + Size, ay, ay + Long);
            end
            gamePkg::dirLeft: begin
                overlap = meets(ex, ex + Size + Long, ax, ax)
                       && meets(ey, ey + Size, ay, ay + Short);
            end
            gamePkg::dirUp: begin
                overlap = meets(ex, ex + Size, ax, ax + Short)
                       && meets(ey, ey + Size + Long, ay, ay);
            end
            default: begin
                overlap = meets(ex, ex + Size, ax, ax + Long)
                       && meets(ey, ey + Size, ay, ay + Short);
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            hit <= 1'b0;
        end else begin
            hit <= attackOn && overlap;
        end
    end

endmodule

`default_nettype wire

/* source/frameTick.sv */
`timescale 1ns/1ps
`default_nettype none

module frameTick #(
    parameter int TickDivide = 4
) (
    input wire Clk,
    input wire rstN,
    input wire frameClk,
    output logic tick
);

    localparam int CntW = (TickDivide > 1) ? $clog2(TickDivide) : 1;

    logic syncA;
    logic syncB;
    logic edgeSeen;
    logic [CntW-1:0] edgeCnt;

    // Rising edge of the synchronized strobe
    assign edgeSeen = syncA & ~syncB;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            syncA <= 1'b0;
            syncB <= 1'b0;
            edgeCnt <= '0;
            tick <= 1'b0;
        end else begin
            syncA <= frameClk;
            syncB <= syncA;
            tick <= 1'b0;
            if (edgeSeen) begin
                if (edgeCnt == CntW'(TickDivide - 1)) begin
                    edgeCnt <= '0;
                    tick <= 1'b1;
                end else begin
                    edgeCnt <= edgeCnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/lifeCtrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface lifeCtrlIf;

    // Configuration from the register block
    logic [gamePkg::healthW-1:0] damage;
    logic [gamePkg::respawnW-1:0] respawnTime;
    logic scoreClear;

    // Status from the life tracker
    logic [7:0] score;
    logic [gamePkg::healthW-1:0] health;
    logic alive;

    modport regs (
        output damage,
        output respawnTime,
        output scoreClear,
        input score,
        input health,
        input alive
    );

    modport life (
        input damage,
        input respawnTime,
        input scoreClear,
        output score,
        output health,
        output alive
    );

endinterface

`default_nettype wire

/* source/gamePkg.sv */
`default_nettype none

package gamePkg;

    // Datapath widths
    localparam int coordW = 9;
    localparam int healthW = 7;
    localparam int respawnW = 10;

    // Attack box and sprite geometry in pixels
    localparam int attackShort = 16;
    localparam int attackLong = 80;
    localparam int enemySize = 26;

    // Register reset values
    localparam logic [healthW-1:0] damageReset = 7'd100;
    localparam logic [respawnW-1:0] respawnReset = 10'd200;

    typedef enum logic [1:0] {
        dirDown = 2'd0,
        dirLeft = 2'd1,
        dirUp = 2'd2,
        dirRight = 2'd3
    } dirE;

    // APB register map
    typedef enum logic [3:0] {
        regCtrl = 4'h0,
        regDamage = 4'h4,
        regRespawn = 4'h8,
        regStatus = 4'hC
    } regAddrE;

endpackage

`default_nettype wire
